//--- source/mipsPkg.sv
// shared constants and types for the single-cycle MIPS subset
// only add, sub, and, or, slt, lw, sw, beq, j, jal and jr are covered
`default_nettype none

package mipsPkg;

  // ============================================================
  // widths
  // ============================================================
  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;
  // word address into the 128-word data memory
  localparam int memAddrWidth = 7;

  // jal writes its return address here
  localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

  // ============================================================
  // major opcodes and R-type function codes
  // ============================================================
  localparam logic [5:0] opR   = 6'b000000;
  localparam logic [5:0] opJ   = 6'b000010;
  localparam logic [5:0] opJal = 6'b000011;
  localparam logic [5:0] opBeq = 6'b000100;
  localparam logic [5:0] opLw  = 6'b100011;
  localparam logic [5:0] opSw  = 6'b101011;

  localparam logic [5:0] fnJr  = 6'b001000;
  localparam logic [5:0] fnAdd = 6'b100000;
  localparam logic [5:0] fnSub = 6'b100010;
  localparam logic [5:0] fnAnd = 6'b100100;
  localparam logic [5:0] fnOr  = 6'b100101;
  localparam logic [5:0] fnSlt = 6'b101010;

  // alu operations, aluNone yields a zero result
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt,
    aluNone
  } aluOpT;

  // ============================================================
  // instruction word views
  // ============================================================
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rTypeT;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iTypeT;

  // j and jal
  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } jTypeT;

  typedef union packed {
    rTypeT rType;
    iTypeT iType;
    jTypeT jType;
  } instrT;

endpackage

`default_nettype wire

//--- source/ctrlIf.sv
// decoded control bundle, driven only by the instruction decoder
`default_nettype none

interface ctrlIf
  import mipsPkg::*;
();

  logic  regDst;
  logic  aluSrc;
  logic  memToReg;
  logic  regWrite;
  logic  memWrite;
  logic  memRead;
  logic  branch;
  logic  jump;
  // jal
  logic  link;
  // jr
  logic  regJump;
  aluOpT aluOp;

  modport decoder (
    output regDst, aluSrc, memToReg, regWrite, memWrite, memRead,
    output branch, jump, link, regJump, aluOp
  );

  // operand, writeback and memory selection in the top level
  modport datapath (
    input regDst, aluSrc, memToReg, regWrite, memWrite, memRead, link, aluOp
  );

  // next-address selection
  modport pc (
    input branch, jump, regJump
  );

endinterface

`default_nettype wire

//--- source/instrDecoder.sv
// main and alu control, purely combinational from the instruction word
// unknown opcodes decode to no side effects, unknown funct to a zero write
`default_nettype none

module instrDecoder
  import mipsPkg::*;
(
  input  instrT  instr,
  ctrlIf.decoder ctrl
);

  // ============================================================
  // main control
  // ============================================================
  always_comb begin
    // defaults give a no-op
    ctrl.regDst   = 1'b0;
    ctrl.aluSrc   = 1'b0;
    ctrl.memToReg = 1'b0;
    ctrl.regWrite = 1'b0;
    ctrl.memWrite = 1'b0;
    ctrl.memRead  = 1'b0;
    ctrl.branch   = 1'b0;
    ctrl.jump     = 1'b0;
    ctrl.link     = 1'b0;
    ctrl.regJump  = 1'b0;
    ctrl.aluOp    = aluNone;

    unique case (instr.rType.opcode)
      opR: begin
        ctrl.regDst = 1'b1;
        // jr only redirects the pc
        if (instr.rType.funct == fnJr) begin
          ctrl.regJump = 1'b1;
        end else begin
          ctrl.regWrite = 1'b1;
        end
        // alu control from funct
        case (instr.rType.funct)
          fnAdd:   ctrl.aluOp = aluAdd;
          fnSub:   ctrl.aluOp = aluSub;
          fnAnd:   ctrl.aluOp = aluAnd;
          fnOr:    ctrl.aluOp = aluOr;
          fnSlt:   ctrl.aluOp = aluSlt;
          default: ctrl.aluOp = aluNone;
        endcase
      end
      opLw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      // compare by subtraction, zero flag decides
      opBeq: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;
      end
      opJ: begin
        ctrl.jump = 1'b1;
      end
      // index 31 and pc+8 are picked in the top level
      opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/pcUnit.sv
// program counter, cleared to 0 by reset, one instruction per clock
// no alignment check on a jr target
`default_nettype none

module pcUnit
  import mipsPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  ctrlIf.pc                    ctrl,
  input  logic [25:0]          target,
  input  logic [dataWidth-1:0] branchOffset,
  input  logic                 zero,
  input  logic [dataWidth-1:0] jumpReg,
  output logic [dataWidth-1:0] pc,
  output logic [dataWidth-1:0] linkAddr
);

  logic [dataWidth-1:0] pcReg;
  logic [dataWidth-1:0] pcPlus4;
  logic [dataWidth-1:0] branchAddr;
  logic [dataWidth-1:0] jumpAddr;

  assign pcPlus4    = pcReg + 32'd4;
  // offset counts words
  assign branchAddr = pcPlus4 + {branchOffset[dataWidth-3:0], 2'b00};
  // region bits come from pc+4
  assign jumpAddr   = {pcPlus4[31:28], target, 2'b00};

  // ============================================================
  // next-address priority: jump, taken branch, jr, sequential
  // ============================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= '0;
    end else if (ctrl.jump) begin
      pcReg <= jumpAddr;
    end else if (ctrl.branch && zero) begin
      pcReg <= branchAddr;
    end else if (ctrl.regJump) begin
      pcReg <= jumpReg;
    end else begin
      pcReg <= pcPlus4;
    end
  end

  assign pc       = pcReg;
  // return address for jal
  assign linkAddr = pcReg + 32'd8;

endmodule

`default_nettype wire

//--- source/regFile.sv
// 32 x 32 register file, asynchronous reads, one synchronous write port
// register 0 always reads zero
`default_nettype none

module regFile
  import mipsPkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic [regAddrWidth-1:0] rdAddrA,
  input  logic [regAddrWidth-1:0] rdAddrB,
  input  logic                    wrEn,
  input  logic [regAddrWidth-1:0] wrAddr,
  input  logic [dataWidth-1:0]    wrData,
  output logic [dataWidth-1:0]    rdDataA,
  output logic [dataWidth-1:0]    rdDataB
);

  logic [dataWidth-1:0] regs [2**regAddrWidth];

  // whole array cleared while rst is low
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 2**regAddrWidth; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // ============================================================
  // read ports
  // ============================================================
  // no write-through; the new value shows after the edge
  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

//--- source/alu.sv
// 32-bit alu for the supported subset, slt compares signed
`default_nettype none

module alu
  import mipsPkg::*;
(
  input  logic [dataWidth-1:0] opA,
  input  logic [dataWidth-1:0] opB,
  input  aluOpT                op,
  output logic [dataWidth-1:0] result,
  output logic                 zero
);

  always_comb begin
    case (op)
      aluAdd: result = opA + opB;
      aluSub: result = opA - opB;
      aluAnd: result = opA & opB;
      aluOr:  result = opA | opB;
      // single result bit, rest cleared
      aluSlt: result = {{(dataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
      default: result = '0;
    endcase
  end

  // beq looks at this after aluSub
  // high for any op whose result is zero
  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- source/mipsCore.sv
// single-cycle MIPS core, both memories outside and read combinationally
// data port addresses words, ALU result bits 8 down to 2
`default_nettype none

module mipsCore
  import mipsPkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  // instruction port
  output logic [dataWidth-1:0]    instrAddr,
  input  instrT                   instr,
  // data port
  output logic [memAddrWidth-1:0] memAddr,
  output logic [dataWidth-1:0]    memWrData,
  input  logic [dataWidth-1:0]    memRdData,
  output logic                    memWrite,
  output logic                    memRead,
  // register file write port, for observation
  output logic                    wbEn,
  output logic [regAddrWidth-1:0] wbAddr,
  output logic [dataWidth-1:0]    wbData
);

  ctrlIf ctrl ();

  logic [dataWidth-1:0] immExt;
  logic [dataWidth-1:0] rsData;
  logic [dataWidth-1:0] rtData;
  logic [dataWidth-1:0] aluB;
  logic [dataWidth-1:0] aluResult;
  logic                 aluZero;
  logic [dataWidth-1:0] linkAddr;

  // ============================================================
  // control and pc
  // ============================================================
  instrDecoder uDecoder (
    .instr (instr),
    .ctrl  (ctrl.decoder)
  );

  pcUnit uPc (
    .clk          (clk),
    .rst          (rst),
    .ctrl         (ctrl.pc),
    .target       (instr.jType.target),
    .branchOffset (immExt),
    .zero         (aluZero),
    .jumpReg      (rsData),
    .pc           (instrAddr),
    .linkAddr     (linkAddr)
  );

  // ============================================================
  // register file and alu
  // ============================================================
  // sign-extended 16-bit immediate
  assign immExt = {{16{instr.iType.imm[15]}}, instr.iType.imm};

  regFile uRegs (
    .clk     (clk),
    .rst     (rst),
    .rdAddrA (instr.rType.rs),
    .rdAddrB (instr.rType.rt),
    .wrEn    (wbEn),
    .wrAddr  (wbAddr),
    .wrData  (wbData),
    .rdDataA (rsData),
    .rdDataB (rtData)
  );

  // operand b, immediate for lw and sw
  assign aluB = ctrl.aluSrc ? immExt : rtData;

  alu uAlu (
    .opA    (rsData),
    .opB    (aluB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  // ============================================================
  // memory and writeback selection
  // ============================================================
  assign memAddr   = aluResult[memAddrWidth+1:2];
  assign memWrData = rtData;
  assign memWrite  = ctrl.memWrite;
  assign memRead   = ctrl.memRead;

  assign wbEn = ctrl.regWrite;

  // jal overrides both index and data
  always_comb begin
    if (ctrl.link) begin
      wbAddr = linkReg;
      wbData = linkAddr;
    end else begin
      wbAddr = ctrl.regDst ? instr.rType.rd : instr.rType.rt;
      wbData = ctrl.memToReg ? memRdData : aluResult;
    end
  end

endmodule

`default_nettype wire

//--- verif/mipsCoreChk.sv
// concurrent checks bound into mipsCore, reported through $error only
`default_nettype none

module mipsCoreChk
  import mipsPkg::*;
(
  input logic                 clk,
  input logic                 rst,
  input logic [dataWidth-1:0] instrAddr,
  input logic                 memWrite,
  input logic                 memRead,
  input logic                 wbEn
);

  // ============================================================
  // port level rules
  // ============================================================
  // sw never writes back
  assert property (@(posedge clk) disable iff (!rst) !(memWrite && wbEn))
    else $error("memWrite and wbEn are high in the same cycle");

  // only lw reads, and lw always writes back
  assert property (@(posedge clk) disable iff (!rst) memRead |-> wbEn)
    else $error("memRead is high without wbEn");

  // word aligned fetch
  assert property (@(posedge clk) disable iff (!rst) instrAddr[1:0] == 2'b00)
    else $error("instrAddr is not word aligned");

  // first fetch after reset release
  assert property (@(posedge clk) $rose(rst) |-> (instrAddr == '0))
    else $error("instrAddr is not zero in the first cycle after reset");

endmodule

bind mipsCore mipsCoreChk uChk (
  .clk       (clk),
  .rst       (rst),
  .instrAddr (instrAddr),
  .memWrite  (memWrite),
  .memRead   (memRead),
  .wbEn      (wbEn)
);

`default_nettype wire

//--- verif/mipsCoreTb.sv
// testbench for mipsCore, memories modelled here, one straight-line program of six tests
// programs must fit in 128 words, data port wraps on ALU result bits 8 down to 2
`default_nettype none

module mipsCoreTb
  import mipsPkg::*;
();

  typedef logic [dataWidth-1:0] regArrT [32];
  typedef logic [dataWidth-1:0] memArrT [128];

  logic                    clk;
  logic                    rst;
  logic [dataWidth-1:0]    instrAddr;
  instrT                   instr;
  logic [memAddrWidth-1:0] memAddr;
  logic [dataWidth-1:0]    memWrData;
  logic [dataWidth-1:0]    memRdData;
  logic                    memWrite;
  logic                    memRead;
  logic                    wbEn;
  logic [regAddrWidth-1:0] wbAddr;
  logic [dataWidth-1:0]    wbData;

  // DUT memories and model state
  memArrT      imem;
  memArrT      dmem;
  memArrT      mDmem;
  regArrT      mRegs;
  logic [31:0] mPc;
  logic [31:0] emitAddr;
  logic [31:0] testStart [8];
  logic        progReady;
  int          progWords;
  int          testErrors;
  int          passCount;
  int          failCount;
  logic [2:0]  curTest;

  mipsCore DUT (
    .clk       (clk),
    .rst       (rst),
    .instrAddr (instrAddr),
    .instr     (instr),
    .memAddr   (memAddr),
    .memWrData (memWrData),
    .memRdData (memRdData),
    .memWrite  (memWrite),
    .memRead   (memRead),
    .wbEn      (wbEn),
    .wbAddr    (wbAddr),
    .wbData    (wbData)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ============================================================
  // encoders and random source
  // ============================================================
  function automatic logic [31:0] encodeR(input int rs, input int rt, input int rd,
                                          input logic [5:0] funct);
    return {opR, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
  endfunction

  function automatic logic [31:0] encodeI(input logic [5:0] op, input int rs, input int rt,
                                          input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  // takes a byte address
  function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [31:0] addr);
    return {op, addr[27:2]};
  endfunction

  // 16-bit fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic emit(input logic [31:0] w);
    imem[emitAddr[8:2]] = w;
    emitAddr = emitAddr + 32'd4;
    progWords++;
  endtask

  function automatic string testName(input logic [2:0] k);
    case (k)
      3'd0:    return "loads";
      3'd1:    return "r-type arithmetic";
      3'd2:    return "stores";
      3'd3:    return "branches";
      3'd4:    return "jumps and linking";
      default: return "register zero";
    endcase
  endfunction

  task automatic fillMemory();
    logic [15:0] lfsr;
    logic [31:0] word;
    lfsr = 16'd72;
    word = '0;
    for (int i = 0; i < 128; i++) begin
      // one lfsr step per data bit
      for (int b = 0; b < 32; b++) begin
        lfsr = lfsrStep(lfsr);
        word = {word[30:0], lfsr[0]};
      end
      dmem[i[6:0]]  = word;
      mDmem[i[6:0]] = word;
      imem[i[6:0]]  = '0;
    end
  endtask

  // ============================================================
  // program image
  // ============================================================
  task automatic buildProgram();
    logic [31:0] b0;
    emitAddr  = '0;
    progWords = 0;
    // loads into r1..r15 from words 0..14
    testStart[0] = emitAddr;
    for (int r = 1; r <= 15; r++) begin
      emit(encodeI(opLw, 0, r, 4 * (r - 1)));
    end
    testStart[1] = emitAddr;
    emit(encodeR(1, 2, 16, fnAdd));
    emit(encodeR(3, 4, 17, fnSub));
    emit(encodeR(5, 6, 18, fnAnd));
    emit(encodeR(7, 8, 19, fnOr));
    emit(encodeR(9, 10, 20, fnSlt));
    emit(encodeR(10, 9, 21, fnSlt));
    // negated operand, signs differ so a signed and an unsigned compare disagree
    emit(encodeR(0, 9, 23, fnSub));
    emit(encodeR(9, 23, 23, fnSlt));
    // funct not in the subset
    emit(encodeR(1, 2, 22, 6'h3f));
    testStart[2] = emitAddr;
    emit(encodeI(opSw, 0, 16, 32'h100));
    emit(encodeI(opSw, 0, 17, 32'h104));
    // random base, word index wraps within the 128 words
    emit(encodeI(opSw, 5, 18, 32'h10c));
    emit(encodeI(opLw, 0, 24, 32'h100));
    emit(encodeI(opLw, 0, 25, 32'h104));
    emit(encodeI(opLw, 5, 26, 32'h10c));
    testStart[3] = emitAddr;
    emit(encodeI(opBeq, 1, 1, 2));
    emit(encodeR(1, 1, 26, fnAdd));
    emit(encodeR(2, 2, 26, fnAdd));
    emit(encodeI(opBeq, 1, 2, 1));
    emit(encodeR(1, 2, 27, fnAdd));
    emit(encodeI(opBeq, 0, 0, 2));
    emit(encodeI(opBeq, 0, 0, 3));
    emit(encodeR(1, 1, 28, fnAdd));
    // backward hop into the exit branch
    emit(encodeI(opBeq, 0, 0, -3));
    emit(encodeR(2, 2, 28, fnAdd));
    testStart[4] = emitAddr;
    b0 = emitAddr;
    emit(encodeJ(opJ, b0 + 32'd8));
    emit(encodeR(1, 1, 29, fnAdd));
    emit(encodeJ(opJal, b0 + 32'd20));
    emit(encodeR(2, 2, 29, fnAdd));
    emit(encodeJ(opJ, b0 + 32'd28));
    // subroutine
    emit(encodeR(3, 4, 30, fnAdd));
    emit(encodeR(31, 0, 0, fnJr));
    testStart[5] = emitAddr;
    emit(encodeR(1, 2, 0, fnAdd));
    emit(encodeI(opLw, 0, 0, 0));
    emit(encodeR(0, 5, 23, fnAdd));
    emit(encodeR(5, 0, 24, fnOr));
    // end address, parks on itself
    testStart[6] = emitAddr;
    emit(encodeJ(opJ, emitAddr));
  endtask

  // ============================================================
  // reference model of one instruction
  // ============================================================
  function automatic void refStep(
    input  instrT       w,
    input  regArrT      regsIn,
    input  memArrT      memIn,
    input  logic [31:0] pcIn,
    output logic [31:0] nextPc,
    output logic        wbEnExp,
    output logic [4:0]  wbAddrExp,
    output logic [31:0] wbDataExp,
    output logic        rdEnExp,
    output logic        stEnExp,
    output logic [6:0]  memAddrExp,
    output logic [31:0] stDataExp
  );
    logic [31:0] rsV;
    logic [31:0] rtV;
    logic [31:0] sext;
    logic [31:0] eff;
    logic [31:0] pc4;
    rsV  = (w.rType.rs == 5'd0) ? 32'd0 : regsIn[w.rType.rs];
    rtV  = (w.rType.rt == 5'd0) ? 32'd0 : regsIn[w.rType.rt];
    pc4  = pcIn + 32'd4;
    sext = {{16{w.iType.imm[15]}}, w.iType.imm};
    eff  = rsV + sext;
    nextPc     = pc4;
    wbEnExp    = 1'b0;
    wbAddrExp  = '0;
    wbDataExp  = '0;
    rdEnExp    = 1'b0;
    stEnExp    = 1'b0;
    memAddrExp = eff[8:2];
    stDataExp  = rtV;
    case (w.rType.opcode)
      opR: begin
        if (w.rType.funct == fnJr) begin
          nextPc = rsV;
        end else begin
          wbEnExp   = 1'b1;
          wbAddrExp = w.rType.rd;
          case (w.rType.funct)
            fnAdd:   wbDataExp = rsV + rtV;
            fnSub:   wbDataExp = rsV - rtV;
            fnAnd:   wbDataExp = rsV & rtV;
            fnOr:    wbDataExp = rsV | rtV;
            fnSlt:   wbDataExp = ($signed(rsV) < $signed(rtV)) ? 32'd1 : 32'd0;
            default: wbDataExp = 32'd0;
          endcase
        end
      end
      opLw: begin
        wbEnExp   = 1'b1;
        rdEnExp   = 1'b1;
        wbAddrExp = w.iType.rt;
        wbDataExp = memIn[eff[8:2]];
      end
      opSw: stEnExp = 1'b1;
      opBeq: begin
        if (rsV == rtV) begin
          nextPc = pc4 + {sext[29:0], 2'b00};
        end
      end
      opJ: nextPc = {pc4[31:28], w.jType.target, 2'b00};
      opJal: begin
        nextPc    = {pc4[31:28], w.jType.target, 2'b00};
        wbEnExp   = 1'b1;
        wbAddrExp = 5'd31;
        wbDataExp = pcIn + 32'd8;
      end
      default: begin
      end
    endcase
  endfunction

  task automatic checkField(input string field, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at time %0t: %s is %h, expected %h", $time, field, got, exp);
      testErrors++;
    end
  endtask

  // ============================================================
  // stimulus and data memory
  // ============================================================
  initial begin
    rst       = 1'b0;
    instr     = '0;
    memRdData = '0;
    progReady = 1'b0;
    fillMemory();
    buildProgram();
    progReady = 1'b1;
    repeat (16) @(posedge clk);
    #1 rst = 1'b1;
    forever begin
      instr = imem[instrAddr[8:2]];
      #1 memRdData = dmem[memAddr];
      @(posedge clk);
      // store lands at the edge
      if (memWrite) begin
        dmem[memAddr] <= memWrData;
      end
      #1;
    end
  end

  // ============================================================
  // comparing process
  // ============================================================
  initial begin
    logic [31:0] expPc;
    logic        expWbEn;
    logic [4:0]  expWbAddr;
    logic [31:0] expWbData;
    logic        expRd;
    logic        expSt;
    logic [6:0]  expMemAddr;
    logic [31:0] expStData;
    mPc        = '0;
    curTest    = '0;
    testErrors = 0;
    passCount  = 0;
    failCount  = 0;
    for (int i = 0; i < 32; i++) begin
      mRegs[i[4:0]] = '0;
    end
    @(posedge rst);
    #2;
    while (curTest != 3'd6) begin
      refStep(imem[mPc[8:2]], mRegs, mDmem, mPc, expPc, expWbEn, expWbAddr, expWbData,
              expRd, expSt, expMemAddr, expStData);
      checkField("instrAddr", instrAddr, mPc);
      checkField("wbEn", {31'b0, wbEn}, {31'b0, expWbEn});
      checkField("memWrite", {31'b0, memWrite}, {31'b0, expSt});
      checkField("memRead", {31'b0, memRead}, {31'b0, expRd});
      if (expWbEn) begin
        checkField("wbAddr", {27'b0, wbAddr}, {27'b0, expWbAddr});
        checkField("wbData", wbData, expWbData);
      end
      if (expRd || expSt) begin
        checkField("memAddr", {25'b0, memAddr}, {25'b0, expMemAddr});
      end
      if (expSt) begin
        checkField("memWrData", memWrData, expStData);
        mDmem[expMemAddr] = expStData;
      end
      // register zero never changes
      if (expWbEn && (expWbAddr != 5'd0)) begin
        mRegs[expWbAddr] = expWbData;
      end
      mPc = expPc;
      if (mPc == testStart[curTest + 3'd1]) begin
        if (testErrors == 0) begin
          $display("test %0d %s: passed", curTest + 3'd1, testName(curTest));
          passCount++;
        end else begin
          $display("test %0d %s: failed with %0d mismatches", curTest + 3'd1,
                   testName(curTest), testErrors);
          failCount++;
        end
        testErrors = 0;
        curTest    = curTest + 3'd1;
      end
      if (curTest != 3'd6) begin
        @(posedge clk);
        #3;
      end
    end
    $display("%0d tests passed, %0d tests failed", passCount, failCount);
    if (failCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // reset time plus one cycle per program word, with slack for loops
  initial begin
    wait (progReady);
    #((16 + progWords) * 4 + 400);
    $display("Watchdog timeout: the program never reached its end address");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
source/mipsPkg.sv
source/ctrlIf.sv
source/instrDecoder.sv
source/pcUnit.sv
source/regFile.sv
source/alu.sv
source/mipsCore.sv
verif/mipsCoreChk.sv
verif/mipsCoreTb.sv

//--- run.sh
#!/bin/sh
# build and run the mipsCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module mipsCoreTb \
  -f project.f \
  -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

./obj_dir/VmipsCoreTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test completed successfully" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi
